// ==== rtl/xgmii_tx_pkg.sv ====
// shared widths and codes; lane 0 is the low byte of a word, keep_to_count expects contiguous keep
package xgmii_tx_pkg;

    localparam int data_w = 64;
    localparam int lanes  = 8;

    // xgmii control characters
    localparam logic [7:0] xgmii_idle  = 8'h07;
    localparam logic [7:0] xgmii_start = 8'hfb;
    localparam logic [7:0] xgmii_term  = 8'hfd;
    localparam logic [7:0] xgmii_error = 8'hfe;

    // start character in lane 0, then preamble and sfd
    localparam logic [data_w-1:0] xgmii_preamble = {8'hd5, {6{8'h55}}, xgmii_start};

    // reflected ethernet crc-32
    localparam logic [31:0] crc_poly = 32'hedb88320;
    localparam logic [31:0] crc_init = 32'hffffffff;

    typedef logic [3:0] byte_count_t;

    typedef enum logic [2:0] {
        idle,
        payload,
        fcs_lo,
        fcs_hi,
        ifg
    } tx_state_e;

    typedef enum logic [2:0] {
        idle_word,
        start_word,
        data_word,
        fcs_lo_word,
        fcs_hi_word,
        error_word
    } tx_word_e;

    // highest kept lane plus one
    function automatic byte_count_t keep_to_count(input logic [lanes-1:0] keep);
        byte_count_t n;
        n = '0;
        for (int i = 0; i < lanes; i++) begin
            if (keep[i]) begin
                n = byte_count_t'(i + 1);
            end
        end
        return n;
    endfunction

endpackage

// ==== rtl/tx_beat_if.sv ====
// one held input beat; fields only change when the source accepts a new beat
interface tx_beat_if import xgmii_tx_pkg::*; ();

    logic [data_w-1:0] data;
    byte_count_t       count;
    logic              last;
    logic              error;

    // decode stage
    modport src (output data, count, last, error);

    // frame state machine
    modport fsm (input count, last, error);

    // fcs engine and word encoder
    modport sink (input data, count);

endinterface

// ==== rtl/axis_beat_decode.sv ====
// registers each accepted beat with unkept bytes zeroed; tkeep must be contiguous from lane 0
module axis_beat_decode import xgmii_tx_pkg::*; (
    input  logic              clk,
    input  logic              reset_crc,
    input  logic [data_w-1:0] s_tdata,
    input  logic [lanes-1:0]  s_tkeep,
    input  logic              s_tvalid,
    input  logic              s_tready,
    input  logic              s_tlast,
    input  logic              s_tuser,
    tx_beat_if.src            beat
);

    logic [data_w-1:0] masked;
    logic              accept;

    assign accept = s_tvalid && s_tready;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            masked[i*8 +: 8] = s_tkeep[i] ? s_tdata[i*8 +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            beat.count <= '0;
            beat.last  <= 1'b0;
            beat.error <= 1'b0;
        end else if (accept) begin
            beat.count <= keep_to_count(s_tkeep);
            beat.last  <= s_tlast;
            beat.error <= s_tuser;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            beat.data <= masked;
        end
    end

endmodule

// ==== rtl/tx_frame_fsm.sv ====
// frame sequencer; tvalid must stay high for a whole frame, ifg_bytes from 12 to 64
module tx_frame_fsm import xgmii_tx_pkg::*; #(
    parameter int ifg_bytes = 12
) (
    input  logic     clk,
    input  logic     reset_crc,
    input  logic     s_tvalid,
    input  logic     s_tlast,
    input  logic     s_tuser,
    tx_beat_if.fsm   beat,
    output logic     s_tready,
    output logic     crc_clear,
    output logic     crc_update,
    output tx_word_e word_sel
);

    tx_state_e   state;
    tx_state_e   state_next;
    logic [6:0]  gap_cnt;
    logic [6:0]  gap_cnt_next;
    logic        ready_next;
    logic        accept;
    logic [3:0]  term_idles;
    logic [6:0]  gap_load;

    assign accept = s_tvalid && s_tready;

    // idles that share the word with the terminate character
    assign term_idles = (beat.count < 4'd4) ? 4'd3 - beat.count : 4'd11 - beat.count;
    assign gap_load   = 7'(ifg_bytes) - 7'(term_idles);

    always_comb begin
        state_next   = state;
        gap_cnt_next = gap_cnt;
        ready_next   = 1'b0;
        crc_clear    = 1'b0;
        crc_update   = 1'b0;
        word_sel     = idle_word;

        case (state)
            idle: begin
                crc_clear  = 1'b1;
                ready_next = !(accept && s_tlast);
                if (accept) begin
                    word_sel   = start_word;
                    state_next = payload;
                end
            end
            payload: begin
                if (!beat.last) begin
                    word_sel   = data_word;
                    crc_update = 1'b1;
                    ready_next = !(accept && s_tlast);
                    // aborted frame, the running crc will never be sent
                    crc_clear  = accept && s_tlast && s_tuser;
                end else if (beat.error) begin
                    word_sel     = error_word;
                    gap_cnt_next = 7'(ifg_bytes);
                    state_next   = ifg;
                end else begin
                    word_sel = fcs_lo_word;
                    if (beat.count < 4'd4) begin
                        gap_cnt_next = gap_load;
                        state_next   = ifg;
                    end else begin
                        state_next = fcs_hi;
                    end
                end
            end
            fcs_hi: begin
                word_sel     = fcs_hi_word;
                gap_cnt_next = gap_load;
                state_next   = ifg;
            end
            ifg: begin
                crc_clear = 1'b1;
                // this idle word covers what is left of the gap
                if (gap_cnt <= 7'd8) begin
                    ready_next = 1'b1;
                    state_next = idle;
                end else begin
                    gap_cnt_next = gap_cnt - 7'd8;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state    <= idle;
            gap_cnt  <= '0;
            s_tready <= 1'b0;
        end else begin
            state    <= state_next;
            gap_cnt  <= gap_cnt_next;
            s_tready <= ready_next;
        end
    end

endmodule

// ==== rtl/eth_fcs64.sv ====
// crc-32 over the held beat; fcs is valid for the last beat and holds while crc_update is low
module eth_fcs64 import xgmii_tx_pkg::*; (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic        crc_clear,
    input  logic        crc_update,
    tx_beat_if.sink     beat,
    output logic [31:0] fcs
);

    logic [31:0] crc_state;
    logic [31:0] crc_full;
    logic [31:0] crc_part;

    // one byte through the reflected lfsr
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? (c >> 1) ^ crc_poly : c >> 1;
        end
        return c;
    endfunction

    // partial result taken after the last counted byte
    always_comb begin
        crc_full = crc_state;
        crc_part = crc_state;
        for (int i = 0; i < lanes; i++) begin
            crc_full = crc_byte(crc_full, beat.data[i*8 +: 8]);
            if (i + 1 == int'(beat.count)) begin
                crc_part = crc_full;
            end
        end
    end

    assign fcs = ~crc_part;

    always_ff @(posedge clk) begin
        if (reset_crc || crc_clear) begin
            crc_state <= crc_init;
        end else if (crc_update) begin
            crc_state <= crc_full;
        end
    end

endmodule

// ==== rtl/xgmii_word_encode.sv ====
// registered xgmii word per word kind; start always in lane 0, fcs sent low byte first
module xgmii_word_encode import xgmii_tx_pkg::*; (
    input  logic              clk,
    input  logic              reset_crc,
    input  tx_word_e          word_sel,
    tx_beat_if.sink           beat,
    input  logic [31:0]       fcs,
    output logic [data_w-1:0] xgmii_txd,
    output logic [lanes-1:0]  xgmii_txc
);

    logic [2*data_w-1:0] data_ext;
    logic [2*data_w-1:0] tail_d;
    logic [2*lanes-1:0]  tail_c;
    logic [data_w-1:0]   txd_next;
    logic [lanes-1:0]    txc_next;

    assign data_ext = {{data_w{1'b0}}, beat.data};

    // frame end over two words: data, fcs, terminate, idles
    always_comb begin
        for (int i = 0; i < 2*lanes; i++) begin
            if (i < int'(beat.count)) begin
                tail_d[i*8 +: 8] = data_ext[i*8 +: 8];
                tail_c[i]        = 1'b0;
            end else if (i < int'(beat.count) + 4) begin
                tail_d[i*8 +: 8] = fcs[(i - int'(beat.count))*8 +: 8];
                tail_c[i]        = 1'b0;
            end else if (i == int'(beat.count) + 4) begin
                tail_d[i*8 +: 8] = xgmii_term;
                tail_c[i]        = 1'b1;
            end else begin
                tail_d[i*8 +: 8] = xgmii_idle;
                tail_c[i]        = 1'b1;
            end
        end
    end

    always_comb begin
        txd_next = {lanes{xgmii_idle}};
        txc_next = '1;
        case (word_sel)
            start_word: begin
                txd_next = xgmii_preamble;
                txc_next = {{(lanes-1){1'b0}}, 1'b1};
            end
            data_word: begin
                txd_next = beat.data;
                txc_next = '0;
            end
            fcs_lo_word: begin
                txd_next = tail_d[data_w-1:0];
                txc_next = tail_c[lanes-1:0];
            end
            fcs_hi_word: begin
                txd_next = tail_d[2*data_w-1:data_w];
                txc_next = tail_c[2*lanes-1:lanes];
            end
            error_word: begin
                txd_next = {{3{xgmii_idle}}, xgmii_term, {4{xgmii_error}}};
                txc_next = '1;
            end
            default: begin
                txd_next = {lanes{xgmii_idle}};
                txc_next = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            xgmii_txd <= {lanes{xgmii_idle}};
            xgmii_txc <= '1;
        end else begin
            xgmii_txd <= txd_next;
            xgmii_txc <= txc_next;
        end
    end

endmodule

// ==== rtl/xgmii_tx_top.sv ====
// axis to xgmii transmitter; no padding, no deficit idle, tvalid held through each frame
module xgmii_tx_top import xgmii_tx_pkg::*; #(
    parameter int ifg_bytes = 12
) (
    input  logic              clk,
    input  logic              reset_crc,
    input  logic [data_w-1:0] s_tdata,
    input  logic [lanes-1:0]  s_tkeep,
    input  logic              s_tvalid,
    output logic              s_tready,
    input  logic              s_tlast,
    input  logic              s_tuser,
    output logic [data_w-1:0] xgmii_txd,
    output logic [lanes-1:0]  xgmii_txc
);

    logic        crc_clear;
    logic        crc_update;
    logic [31:0] fcs;
    tx_word_e    word_sel;

    tx_beat_if beat_bus ();

    axis_beat_decode axis_beat_decode_i (
        .clk       (clk),
        .reset_crc (reset_crc),
        .s_tdata   (s_tdata),
        .s_tkeep   (s_tkeep),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .s_tlast   (s_tlast),
        .s_tuser   (s_tuser),
        .beat      (beat_bus.src)
    );

    tx_frame_fsm #(
        .ifg_bytes (ifg_bytes)
    ) tx_frame_fsm_i (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .s_tvalid   (s_tvalid),
        .s_tlast    (s_tlast),
        .s_tuser    (s_tuser),
        .beat       (beat_bus.fsm),
        .s_tready   (s_tready),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .word_sel   (word_sel)
    );

    eth_fcs64 eth_fcs64_i (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .beat       (beat_bus.sink),
        .fcs        (fcs)
    );

    xgmii_word_encode xgmii_word_encode_i (
        .clk       (clk),
        .reset_crc (reset_crc),
        .word_sel  (word_sel),
        .beat      (beat_bus.sink),
        .fcs       (fcs),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc)
    );

endmodule

// ==== verif/xgmii_tx_asserts.sv ====
// port checks bound into xgmii_tx_top; a frame counts as open from its first accepted beat
module xgmii_tx_asserts import xgmii_tx_pkg::*; (
    input logic             clk,
    input logic             reset_crc,
    input logic             s_tvalid,
    input logic             s_tready,
    input logic             s_tlast,
    input logic [lanes-1:0] xgmii_txc
);

    timeunit 1ns;
    timeprecision 1ps;

    logic accept;
    logic in_frame;

    assign accept = s_tvalid && s_tready;

    // set by a first beat, cleared by the last
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            in_frame <= 1'b0;
        end else if (accept) begin
            in_frame <= !s_tlast;
        end
    end

    valid_held: assert property (
        @(posedge clk) disable iff (reset_crc) in_frame |-> s_tvalid
    ) else $error("s_tvalid dropped inside a frame");

    idle_between_frames: assert property (
        @(posedge clk) disable iff (reset_crc) (s_tready && !in_frame) |-> (xgmii_txc == '1)
    ) else $error("xgmii_txc carries data while no frame is open");

    ready_drop_after_last: assert property (
        @(posedge clk) disable iff (reset_crc) (accept && s_tlast) |=> !s_tready
    ) else $error("s_tready still high after a last beat");

endmodule

// ==== verif/xgmii_tx_tb.sv ====
// drives whole frames into xgmii_tx_top and checks the xgmii stream; ifg_bytes 12, start in lane 0
module xgmii_tx_tb import xgmii_tx_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ifg_bytes  = 12;
    localparam int wait_limit = 400;

    logic              clk;
    logic              reset_crc;
    logic [data_w-1:0] s_tdata;
    logic [lanes-1:0]  s_tkeep;
    logic              s_tvalid;
    logic              s_tready;
    logic              s_tlast;
    logic              s_tuser;
    logic [data_w-1:0] xgmii_txd;
    logic [lanes-1:0]  xgmii_txc;

    // payload of the frame being sent
    logic [7:0] pay[$];
    // expected bytes of all frames in flight
    logic [7:0] exp_bytes[$];
    int         exp_len[$];
    bit         exp_err[$];
    string      exp_name[$];
    logic [7:0] got[$];
    logic       got_ctl[$];

    string test_name;
    int    errors      = 0;
    int    timeouts    = 0;
    int    frames_sent = 0;
    int    frames_rcvd = 0;
    int    starts_seen = 0;
    int    gap_idles   = 0;
    bit    in_frame    = 1'b0;
    bit    seen_term   = 1'b0;

    xgmii_tx_top #(.ifg_bytes(ifg_bytes)) xgmii_tx_top_i (.*);

    bind xgmii_tx_top xgmii_tx_asserts xgmii_tx_asserts_i (.*);

    always #10 clk = ~clk;

    // bitwise crc-32 with lsb first
    function automatic logic [31:0] ref_fcs();
        logic [31:0] crc;
        logic        fb;
        crc = crc_init;
        foreach (pay[n]) begin
            for (int j = 0; j < 8; j++) begin
                fb  = crc[0] ^ pay[n][j];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ crc_poly;
                end
            end
        end
        return ~crc;
    endfunction

    // expected bytes from the start character up to the terminate character
    function automatic int build_expected(input bit err);
        logic [31:0] fcs;
        int          n0;
        int          keep_n;
        n0 = exp_bytes.size();
        for (int i = 0; i < lanes; i++) begin
            exp_bytes.push_back(xgmii_preamble[i*8 +: 8]);
        end
        if (err) begin
            // error word takes the place of the whole last beat
            keep_n = ((pay.size() - 1) / lanes) * lanes;
            for (int i = 0; i < keep_n; i++) begin
                exp_bytes.push_back(pay[i]);
            end
            for (int i = 0; i < 4; i++) begin
                exp_bytes.push_back(xgmii_error);
            end
        end else begin
            fcs = ref_fcs();
            foreach (pay[i]) begin
                exp_bytes.push_back(pay[i]);
            end
            for (int i = 0; i < 4; i++) begin
                exp_bytes.push_back(fcs[i*8 +: 8]);
            end
        end
        exp_bytes.push_back(xgmii_term);
        return exp_bytes.size() - n0;
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        while (!s_tready && n < wait_limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!s_tready) begin
            $display("s_tready stayed low for %0d cycles in %s", wait_limit, test_name);
            timeouts++;
        end
    endtask

    task automatic wait_frames();
        int n;
        n = 0;
        while (frames_rcvd < frames_sent && n < wait_limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (frames_rcvd < frames_sent) begin
            $display("only %0d of %0d frames came out in %s", frames_rcvd, frames_sent, test_name);
            timeouts++;
        end
    endtask

    // hold keeps tvalid up so the next frame follows at once
    task automatic send_frame(input int len, input bit err, input bit hold);
        int nbeats;
        int n;
        pay.delete();
        for (int i = 0; i < len; i++) begin
            pay.push_back(8'($urandom));
        end
        n = build_expected(err);
        exp_len.push_back(n);
        exp_err.push_back(err);
        exp_name.push_back(test_name);
        frames_sent++;
        nbeats = (len + lanes - 1) / lanes;
        for (int b = 0; b < nbeats; b++) begin
            // junk in the unkept lanes
            s_tdata = {$urandom, $urandom};
            s_tkeep = '0;
            for (int i = 0; i < lanes; i++) begin
                if (b * lanes + i < len) begin
                    s_tdata[i*8 +: 8] = pay[b * lanes + i];
                    s_tkeep[i]        = 1'b1;
                end
            end
            s_tvalid = 1'b1;
            s_tlast  = (b == nbeats - 1);
            s_tuser  = err && s_tlast;
            wait_ready();
            @(posedge clk);
            #2;
        end
        if (!hold) begin
            s_tvalid = 1'b0;
            s_tlast  = 1'b0;
            s_tuser  = 1'b0;
        end
    endtask

    task automatic check_frame();
        int         len;
        string      name;
        logic [7:0] want;
        logic       want_c;
        bit         err;
        bit         bad;
        frames_rcvd++;
        if (exp_len.size() == 0) begin
            $display("a frame came out that was never sent, in %s", test_name);
            errors++;
        end else begin
            len  = exp_len.pop_front();
            err  = exp_err.pop_front();
            name = exp_name.pop_front();
            bad  = 1'b0;
            if (got.size() != len) begin
                $display("ERR %s frame length expected %0d actual %0d", name, len, got.size());
                errors++;
            end
            for (int i = 0; i < len; i++) begin
                want = exp_bytes.pop_front();
                // start, terminate and error characters are control, the rest data
                want_c = (i == 0) || (i == len - 1) || (err && i >= len - 5);
                if (!bad && i < got.size() && got[i] !== want) begin
                    $display("ERR %s byte %0d expected %h actual %h", name, i, want, got[i]);
                    errors++;
                    bad = 1'b1;
                end
                if (!bad && i < got.size() && got_ctl[i] !== want_c) begin
                    $display("ERR %s control bit %0d expected %b actual %b",
                             name, i, want_c, got_ctl[i]);
                    errors++;
                    bad = 1'b1;
                end
            end
        end
    endtask

    task automatic take_lane(input logic [7:0] b, input logic ctl, input int lane);
        if (!in_frame) begin
            if (ctl && b == xgmii_start) begin
                if (lane != 0) begin
                    $display("ERR %s start lane expected 0 actual %0d", test_name, lane);
                    errors++;
                end
                if (seen_term && gap_idles < ifg_bytes) begin
                    $display("ERR %s idle gap expected %0d actual %0d",
                             test_name, ifg_bytes, gap_idles);
                    errors++;
                end
                in_frame = 1'b1;
                starts_seen++;
                got.delete();
                got_ctl.delete();
                got.push_back(b);
                got_ctl.push_back(ctl);
            end else if (ctl && b == xgmii_idle) begin
                gap_idles++;
            end else begin
                $display("ERR %s between frames expected %h actual %h with control %b",
                         test_name, xgmii_idle, b, ctl);
                errors++;
            end
        end else begin
            got.push_back(b);
            got_ctl.push_back(ctl);
            if (ctl && b == xgmii_term) begin
                in_frame  = 1'b0;
                seen_term = 1'b1;
                gap_idles = 0;
                check_frame();
            end
        end
    endtask

    // outputs sampled at the falling edge
    always @(negedge clk) begin
        if (!reset_crc) begin
            for (int i = 0; i < lanes; i++) begin
                take_lane(xgmii_txd[i*8 +: 8], xgmii_txc[i], i);
            end
        end
    end

    initial begin
        clk       = 1'b0;
        reset_crc = 1'b1;
        s_tdata   = '0;
        s_tkeep   = '0;
        s_tvalid  = 1'b0;
        s_tlast   = 1'b0;
        s_tuser   = 1'b0;
        void'($urandom(32'h5837));

        test_name = "reset";
        repeat (16) @(posedge clk);
        #2;
        reset_crc = 1'b0;
        if (s_tready !== 1'b0) begin
            $display("ERR reset s_tready expected 0 actual %b", s_tready);
            errors++;
        end
        wait_ready();
        repeat (4) begin
            @(posedge clk);
            #2;
        end
        if (xgmii_txc !== {lanes{1'b1}}) begin
            $display("ERR reset xgmii_txc expected ff actual %h", xgmii_txc);
            errors++;
        end
        if (xgmii_txd !== {lanes{xgmii_idle}}) begin
            $display("ERR reset xgmii_txd expected %h actual %h", {lanes{xgmii_idle}}, xgmii_txd);
            errors++;
        end
        if (starts_seen != 0) begin
            $display("ERR reset start characters expected 0 actual %0d", starts_seen);
            errors++;
        end

        // one frame per final byte count
        test_name = "single_frame";
        for (int c = 1; c <= lanes; c++) begin
            send_frame(64 + 8 * int'($urandom % 4) + c, 1'b0, 1'b0);
            wait_frames();
        end

        test_name = "back_to_back";
        for (int k = 0; k < 6; k++) begin
            send_frame(60 + int'($urandom % 41), 1'b0, k < 5);
        end
        wait_frames();

        test_name = "tuser_abort";
        send_frame(70, 1'b1, 1'b0);
        send_frame(83, 1'b1, 1'b0);
        wait_frames();

        test_name = "random_run";
        for (int k = 0; k < 20; k++) begin
            send_frame(60 + int'($urandom % 41), 1'b0, 1'b0);
            repeat (int'($urandom % 6)) begin
                @(posedge clk);
                #2;
            end
        end
        wait_frames();
        if (frames_rcvd != frames_sent || exp_len.size() != 0) begin
            $display("ERR random_run frames expected %0d actual %0d", frames_sent, frames_rcvd);
            errors++;
        end

        $display("errors %0d timeouts %0d frames sent %0d received %0d",
                 errors, timeouts, frames_sent, frames_rcvd);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/xgmii_tx_pkg.sv
rtl/tx_beat_if.sv
rtl/axis_beat_decode.sv
rtl/tx_frame_fsm.sv
rtl/eth_fcs64.sv
rtl/xgmii_word_encode.sv
rtl/xgmii_tx_top.sv
verif/xgmii_tx_asserts.sv
verif/xgmii_tx_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = xgmii_tx_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
